/* verif/excp_tests.txt */
# Columns: op a b c d e, all hex, one line per clock cycle
# 1 csr write: addr data | 2 csr read: addr expected use_model | 3 commit: pc ecode badv flags
# 4 lines: ti ti_clr swi swi_clr hwi | 5 idle | 6 redirect: valid pc | 7 int_status: expected
# Reset state
6 0 0 0 0 0
2 0 0 0 0 0
7 0 0 0 0 0
# ADEF trap to EENTRY
1 c 1c000040 0 0 0
1 88 1c001000 0 0 0
1 0 7 0 0 0
2 c 1c000040 0 0 0
3 1c000100 8 deadbeef 1 0
6 1 1c000040 0 0 0
2 5 80000 0 0 0
2 6 0 1 0 0
2 7 deadbeef 0 0 0
2 0 0 1 0 0
2 1 7 1 0 0
# ertn back to ERA
3 1c000200 0 0 2 0
6 1 1c000100 0 0 0
2 0 7 0 0 0
# TLBR entry, SYS keeps BADV
3 1c000300 3f 12345678 1 0
6 1 1c001000 0 0 0
2 7 12345678 0 0 0
3 1c000400 b badc0de 1 0
6 1 1c000040 0 0 0
2 7 12345678 0 0 0
2 5 b0000 0 0 0
2 6 0 1 0 0
# Younger commit behind a trap
3 1c000500 9 11 1 0
3 1c000600 8 22 1 0
6 0 0 0 0 0
2 6 1c000500 0 0 0
2 7 11 0 0 0
# Interrupt from hwi line 3
1 4 20 0 0 0
1 0 4 0 0 0
4 0 0 0 0 8
5 0 0 0 0 0
7 20 0 0 0 0
3 1c000700 0 0 0 0
6 1 1c000040 0 0 0
2 5 0 0 0 0
2 6 0 1 0 0
2 1 4 1 0 0
# Timer bit set, then cleared
4 1 0 0 0 8
4 0 1 0 0 8
7 820 0 0 0 0
7 20 0 0 0 0
# IE clear blocks the interrupt
3 1c000800 0 0 0 0
6 0 0 0 0 0
2 0 0 1 0 0

/* list.f */
+incdir+verilog
verilog/excp_pkg.sv
verilog/commit_req_stage.sv
verilog/int_pending.sv
verilog/excp_unit.sv
verilog/excp_csr.sv
verilog/excp_top.sv
verif/tb_clock.sv
verif/excp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module excp_tb -o excp_sim

./obj_dir/excp_sim

/* verif/excp_tb.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module excp_tb;

    import excp_pkg::*;

    logic                clk;
    logic                rst_n;
    logic                commit_valid;
    logic [`ADDR_W-1:0]  commit_pc;
    logic                commit_excp;
    ecode_t              commit_ecode;
    logic [`ADDR_W-1:0]  commit_badv;
    logic                commit_ertn;
    logic                ti_in;
    logic                ti_clr;
    logic [1:0]          swi_in;
    logic [1:0]          swi_clr;
    logic [`HWI_N-1:0]   hwi_in;
    logic                csr_we;
    csr_addr_t           csr_addr;
    logic [`ADDR_W-1:0]  csr_wdata;
    csr_addr_t           csr_raddr;
    logic                redirect_valid;
    logic [`ADDR_W-1:0]  redirect_pc;
    logic [`ADDR_W-1:0]  csr_rdata;
    logic [`INT_W-1:0]   int_status;

    logic [5:0][31:0]    tests[$];
    int                  cycle_limit;
    int                  cycles;

    // Reference model of commit register, pending latch and CSRs
    logic                m_rv;
    logic                m_rexcp;
    logic                m_rertn;
    logic [31:0]         m_rpc;
    logic [31:0]         m_rbadv;
    logic [5:0]          m_recode;
    logic [12:0]         m_pend;
    logic [12:0]         m_ivec;
    logic [12:0]         m_lie;
    logic [1:0]          m_plv;
    logic [1:0]          m_pplv;
    logic                m_ie;
    logic                m_pie;
    logic [5:0]          m_ecode;
    logic [31:0]         m_era;
    logic [31:0]         m_badv;
    logic [31:0]         m_eentry;
    logic [31:0]         m_tlbrentry;
    logic                m_int;
    logic                m_trap;
    logic                m_ret;
    logic                m_redir;
    logic [5:0]          m_code;
    logic [31:0]         m_redir_pc;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    excp_top DUT (.*);

    ////////////////////////////////////////
    // Checks and model
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Codes that record the faulting address
    function automatic logic records_badv(input logic [5:0] code);
        case (code)
            TLBR, ADEF, ADEM, ALE, PIL, PIS, PIF: return 1'b1;
            default:                              return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] csr_expect(input logic [13:0] addr);
        case (addr)
            CRMD:      return {29'b0, m_ie, m_plv};
            PRMD:      return {29'b0, m_pie, m_pplv};
            ECFG:      return {19'b0, m_lie};
            ESTAT:     return {10'b0, m_ecode, 16'b0};
            ERA:       return m_era;
            BADV:      return m_badv;
            EENTRY:    return m_eentry;
            TLBRENTRY: return m_tlbrentry;
            default:   return 32'h0;
        endcase
    endfunction

    task automatic reset_model();
        {m_rv, m_rexcp, m_rertn, m_ie, m_pie} = 5'b0;
        {m_rpc, m_rbadv, m_era, m_badv, m_eentry, m_tlbrentry} = '0;
        {m_pend, m_ivec, m_lie} = '0;
        {m_plv, m_pplv} = 4'b0;
        {m_recode, m_ecode} = 12'b0;
    endtask

    // Decision for the request held this cycle
    task automatic compute_outputs();
        m_int   = m_rv & m_ie & (|(m_ivec & m_lie));
        m_trap  = m_int | (m_rv & m_rexcp);
        m_ret   = m_rv & ~m_trap & m_rertn;
        m_redir = m_trap | m_ret;
        m_code  = m_int ? 6'h00 : m_recode;
        if (m_trap) begin
            m_redir_pc = (m_code == TLBR) ? m_tlbrentry : m_eentry;
        end else begin
            m_redir_pc = m_era;
        end
    endtask

    // State after the coming rising edge
    task automatic advance_model();
        logic [1:0] plv_now;
        logic       ie_now;
        logic [1:0] pplv_now;
        logic       pie_now;
        plv_now  = m_plv;
        ie_now   = m_ie;
        pplv_now = m_pplv;
        pie_now  = m_pie;
        if (csr_we) begin
            case (csr_addr)
                CRMD: begin
                    m_plv = csr_wdata[1:0];
                    m_ie  = csr_wdata[2];
                end
                PRMD: begin
                    m_pplv = csr_wdata[1:0];
                    m_pie  = csr_wdata[2];
                end
                ECFG:      m_lie       = csr_wdata[12:0] & 13'h1bff;
                ERA:       m_era       = csr_wdata;
                BADV:      m_badv      = csr_wdata;
                EENTRY:    m_eentry    = csr_wdata & 32'hffff_ffc0;
                TLBRENTRY: m_tlbrentry = csr_wdata & 32'hffff_ffc0;
                default: ;
            endcase
        end
        if (m_trap) begin
            m_pplv  = plv_now;
            m_pie   = ie_now;
            m_plv   = 2'd0;
            m_ie    = 1'b0;
            m_ecode = m_code;
            m_era   = m_rpc;
            if (!m_int && records_badv(m_recode)) begin
                m_badv = m_rbadv;
            end
        end else if (m_ret) begin
            m_plv = pplv_now;
            m_ie  = pie_now;
        end
        m_ivec  = m_pend;
        m_pend  = (m_pend & ~{1'b0, ti_clr, 1'b0, {`HWI_N{1'b0}}, swi_clr})
                | {1'b0, ti_in, 1'b0, hwi_in, swi_in};
        m_rv    = commit_valid & ~m_redir;
        m_rexcp = m_rv & commit_excp;
        m_rertn = m_rv & commit_ertn;
        if (m_rv) begin
            m_rpc    = commit_pc;
            m_rbadv  = commit_badv;
            m_recode = commit_ecode;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic apply_line(input logic [5:0][31:0] t);
        commit_valid = 1'b0;
        csr_we       = 1'b0;
        ti_clr       = 1'b0;
        swi_clr      = 2'b00;
        case (t[0])
            32'h1: begin
                csr_we    = 1'b1;
                csr_addr  = csr_addr_t'(t[1][13:0]);
                csr_wdata = t[2];
            end
            32'h2: csr_raddr = csr_addr_t'(t[1][13:0]);
            32'h3: begin
                commit_valid = 1'b1;
                commit_pc    = t[1];
                commit_ecode = ecode_t'(t[2][5:0]);
                commit_badv  = t[3];
                commit_excp  = t[4][0];
                commit_ertn  = t[4][1];
            end
            32'h4: begin
                ti_in   = t[1][0];
                ti_clr  = t[2][0];
                swi_in  = t[3][1:0];
                swi_clr = t[4][1:0];
                hwi_in  = t[5][`HWI_N-1:0];
            end
            default: ;
        endcase
    endtask

    task automatic check_line(input logic [5:0][31:0] t);
        check_value("redirect_valid", {31'b0, m_redir}, {31'b0, redirect_valid});
        if (m_redir) begin
            check_value("redirect_pc", m_redir_pc, redirect_pc);
        end
        case (t[0])
            32'h2: check_value($sformatf("csr_rdata[%h]", t[1][13:0]),
                               t[3][0] ? csr_expect(t[1][13:0]) : t[2], csr_rdata);
            32'h6: begin
                check_value("redirect_valid", {31'b0, t[1][0]}, {31'b0, redirect_valid});
                if (t[1][0]) begin
                    check_value("redirect_pc", t[2], redirect_pc);
                end
            end
            32'h7: check_value("int_status", {19'b0, t[1][12:0]}, {19'b0, int_status});
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Some tests failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        int               fd;
        string            line;
        logic [31:0]      f0, f1, f2, f3, f4, f5;
        logic [5:0][31:0] t;
        commit_valid = 1'b0;
        commit_pc    = '0;
        commit_excp  = 1'b0;
        commit_ecode = INT;
        commit_badv  = '0;
        commit_ertn  = 1'b0;
        ti_in        = 1'b0;
        ti_clr       = 1'b0;
        swi_in       = 2'b00;
        swi_clr      = 2'b00;
        hwi_in       = '0;
        csr_we       = 1'b0;
        csr_addr     = CRMD;
        csr_wdata    = '0;
        csr_raddr    = CRMD;
        cycles       = 0;
        cycle_limit  = 20;
        reset_model();

        fd = $fopen("verif/excp_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file verif/excp_tests.txt");
            $display("Some tests failed");
            $fatal(1, "No test file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5) != 6
                    || f0 == 32'h0 || f0 > 32'h7) begin
                    $display("Malformed test line: %s", line);
                    $display("Some tests failed");
                    $fatal(1, "Bad test file");
                end
                t = {f5, f4, f3, f2, f1, f0};
                tests.push_back(t);
            end
        end
        $fclose(fd);
        cycle_limit = 4 * tests.size() + 20;

        // One line per cycle and checked mid-cycle
        @(posedge rst_n);
        foreach (tests[i]) begin
            @(posedge clk);
            #2;
            apply_line(tests[i]);
            #18;
            compute_outputs();
            check_line(tests[i]);
            advance_model();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over 5 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* verilog/excp_top.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module excp_top (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 commit_valid,
    input  logic [`ADDR_W-1:0]   commit_pc,
    input  logic                 commit_excp,
    input  excp_pkg::ecode_t     commit_ecode,
    input  logic [`ADDR_W-1:0]   commit_badv,
    input  logic                 commit_ertn,

    input  logic                 ti_in,
    input  logic                 ti_clr,
    input  logic [1:0]           swi_in,
    input  logic [1:0]           swi_clr,
    input  logic [`HWI_N-1:0]    hwi_in,

    input  logic                 csr_we,
    input  excp_pkg::csr_addr_t  csr_addr,
    input  logic [`ADDR_W-1:0]   csr_wdata,
    input  excp_pkg::csr_addr_t  csr_raddr,

    output logic                 redirect_valid,
    output logic [`ADDR_W-1:0]   redirect_pc,
    output logic [`ADDR_W-1:0]   csr_rdata,
    output logic [`INT_W-1:0]    int_status
);

    import excp_pkg::*;

    logic                req_valid;
    logic                req_excp;
    logic                req_ertn;
    logic [`ADDR_W-1:0]  req_pc;
    logic [`ADDR_W-1:0]  req_badv;
    ecode_t              req_ecode;

    plv_t                crmd_plv;
    plv_t                prmd_pplv;
    logic                crmd_ie;
    logic                prmd_pie;
    logic [`ADDR_W-1:0]  era;
    logic [`ADDR_W-1:0]  eentry;
    logic [`ADDR_W-1:0]  tlbrentry;
    logic [`INT_W-1:0]   ecfg_lie;

    logic                upd_excp;
    ecode_t              upd_ecode;
    logic                upd_badv_we;
    logic [`ADDR_W-1:0]  upd_badv;
    logic [`ADDR_W-1:0]  upd_era;
    logic                upd_ertn;

    commit_req_stage u_commit (
        .clk(clk), .rst_n(rst_n),
        .flush(redirect_valid),
        .commit_valid(commit_valid), .commit_excp(commit_excp),
        .commit_ertn(commit_ertn), .commit_pc(commit_pc),
        .commit_badv(commit_badv), .commit_ecode(commit_ecode),
        .req_valid(req_valid), .req_excp(req_excp), .req_ertn(req_ertn),
        .req_pc(req_pc), .req_badv(req_badv), .req_ecode(req_ecode)
    );

    int_pending u_int (
        .clk(clk), .rst_n(rst_n),
        .ti_in(ti_in), .ti_clr(ti_clr),
        .swi_in(swi_in), .swi_clr(swi_clr),
        .hwi_in(hwi_in),
        .int_vec(int_status)
    );

    excp_unit u_unit (
        .req_valid(req_valid), .req_excp(req_excp), .req_ertn(req_ertn),
        .req_pc(req_pc), .req_badv(req_badv), .req_ecode(req_ecode),
        .int_vec(int_status),
        .crmd_plv(crmd_plv), .prmd_pplv(prmd_pplv),
        .crmd_ie(crmd_ie), .prmd_pie(prmd_pie), .ecfg_lie(ecfg_lie),
        .era(era), .eentry(eentry), .tlbrentry(tlbrentry),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .upd_excp(upd_excp), .upd_ecode(upd_ecode),
        .upd_badv_we(upd_badv_we), .upd_badv(upd_badv),
        .upd_era(upd_era), .upd_ertn(upd_ertn)
    );

    excp_csr u_csr (
        .clk(clk), .rst_n(rst_n),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_raddr(csr_raddr), .csr_rdata(csr_rdata),
        .upd_excp(upd_excp), .upd_ecode(upd_ecode),
        .upd_badv_we(upd_badv_we), .upd_badv(upd_badv),
        .upd_era(upd_era), .upd_ertn(upd_ertn),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie),
        .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie),
        .era(era), .eentry(eentry), .tlbrentry(tlbrentry),
        .ecfg_lie(ecfg_lie)
    );

endmodule

/* verilog/excp_csr.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module excp_csr (
    input  logic                     clk,
    input  logic                     rst_n,

    // Software access
    input  logic                     csr_we,
    input  excp_pkg::csr_addr_t      csr_addr,
    input  logic [`ADDR_W-1:0]       csr_wdata,
    input  excp_pkg::csr_addr_t      csr_raddr,
    output logic [`ADDR_W-1:0]       csr_rdata,

    // Trap and return updates
    input  logic                     upd_excp,
    input  excp_pkg::ecode_t         upd_ecode,
    input  logic                     upd_badv_we,
    input  logic [`ADDR_W-1:0]       upd_badv,
    input  logic [`ADDR_W-1:0]       upd_era,
    input  logic                     upd_ertn,

    // Fields for the decision stage
    output excp_pkg::plv_t           crmd_plv,
    output logic                     crmd_ie,
    output excp_pkg::plv_t           prmd_pplv,
    output logic                     prmd_pie,
    output logic [`ADDR_W-1:0]       era,
    output logic [`ADDR_W-1:0]       eentry,
    output logic [`ADDR_W-1:0]       tlbrentry,
    output logic [`INT_W-1:0]        ecfg_lie
);

    import excp_pkg::*;

    // LIE bit 10 is reserved
    localparam logic [`INT_W-1:0] LIE_MASK = 'h1BFF;

    ecode_t              estat_ecode;
    logic [`ADDR_W-1:0]  badv;

    ////////////////////////////////////////
    // Register update
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_plv    <= KERNEL;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= KERNEL;
            prmd_pie    <= 1'b0;
            estat_ecode <= INT;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            tlbrentry   <= '0;
            ecfg_lie    <= '0;
        end else begin
            if (csr_we) begin
                case (csr_addr)
                    CRMD: begin
                        crmd_plv <= plv_t'(csr_wdata[1:0]);
                        crmd_ie  <= csr_wdata[2];
                    end
                    PRMD: begin
                        prmd_pplv <= plv_t'(csr_wdata[1:0]);
                        prmd_pie  <= csr_wdata[2];
                    end
                    ECFG:      ecfg_lie  <= csr_wdata[`INT_W-1:0] & LIE_MASK;
                    ERA:       era       <= csr_wdata;
                    BADV:      badv      <= csr_wdata;
                    // Entries are 64-byte aligned
                    EENTRY:    eentry    <= {csr_wdata[`ADDR_W-1:6], 6'b0};
                    TLBRENTRY: tlbrentry <= {csr_wdata[`ADDR_W-1:6], 6'b0};
                    default: ;
                endcase
            end

            // Trap side overrides a same-cycle software write
            if (upd_excp) begin
                prmd_pplv   <= crmd_plv;
                prmd_pie    <= crmd_ie;
                crmd_plv    <= KERNEL;
                crmd_ie     <= 1'b0;
                estat_ecode <= upd_ecode;
                era         <= upd_era;
                if (upd_badv_we) begin
                    badv <= upd_badv;
                end
            end else if (upd_ertn) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_comb begin
        csr_rdata = '0;
        case (csr_raddr)
            CRMD:      csr_rdata = {{(`ADDR_W-3){1'b0}}, crmd_ie, crmd_plv};
            PRMD:      csr_rdata = {{(`ADDR_W-3){1'b0}}, prmd_pie, prmd_pplv};
            ECFG:      csr_rdata = {{(`ADDR_W-`INT_W){1'b0}}, ecfg_lie};
            // Ecode sits in bits 21:16
            ESTAT:     csr_rdata = {{(`ADDR_W-22){1'b0}}, estat_ecode, 16'b0};
            ERA:       csr_rdata = era;
            BADV:      csr_rdata = badv;
            EENTRY:    csr_rdata = eentry;
            TLBRENTRY: csr_rdata = tlbrentry;
            default:   csr_rdata = '0;
        endcase
    end

endmodule

/* verilog/excp_unit.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module excp_unit (
    // Request from commit stage
    input  logic                 req_valid,
    input  logic                 req_excp,
    input  logic                 req_ertn,
    input  logic [`ADDR_W-1:0]   req_pc,
    input  logic [`ADDR_W-1:0]   req_badv,
    input  excp_pkg::ecode_t     req_ecode,

    input  logic [`INT_W-1:0]    int_vec,

    // Current CSR state
    input  excp_pkg::plv_t       crmd_plv,
    input  excp_pkg::plv_t       prmd_pplv,
    input  logic                 crmd_ie,
    input  logic                 prmd_pie,
    input  logic [`INT_W-1:0]    ecfg_lie,
    input  logic [`ADDR_W-1:0]   era,
    input  logic [`ADDR_W-1:0]   eentry,
    input  logic [`ADDR_W-1:0]   tlbrentry,

    // Fetch redirect
    output logic                 redirect_valid,
    output logic [`ADDR_W-1:0]   redirect_pc,

    // CSR update
    output logic                 upd_excp,
    output excp_pkg::ecode_t     upd_ecode,
    output logic                 upd_badv_we,
    output logic [`ADDR_W-1:0]   upd_badv,
    output logic [`ADDR_W-1:0]   upd_era,
    output logic                 upd_ertn
);

    import excp_pkg::*;

    logic                int_take;
    logic                excp_take;
    logic                ertn_take;
    logic                badv_code;
    logic                mode_change;
    logic [`ADDR_W-1:0]  entry_pc;

    ////////////////////////////////////////
    // Decision
    ////////////////////////////////////////

    // Bubbles never take an interrupt
    assign int_take  = req_valid & crmd_ie & (|(int_vec & ecfg_lie));
    assign excp_take = ~int_take & req_excp;
    assign ertn_take = ~int_take & ~req_excp & req_ertn;

    assign upd_excp       = int_take | excp_take;
    assign redirect_valid = upd_excp | ertn_take;

    always_comb begin
        if (int_take) begin
            upd_ecode = INT;
        end else begin
            upd_ecode = req_ecode;
        end
    end

    ////////////////////////////////////////
    // Redirect target
    ////////////////////////////////////////

    assign entry_pc    = (upd_ecode == TLBR) ? tlbrentry : eentry;
    assign redirect_pc = upd_excp ? entry_pc : era;

    ////////////////////////////////////////
    // CSR update values
    ////////////////////////////////////////

    // Address-related faults record the bad address
    always_comb begin
        case (req_ecode)
            TLBR, ADEF, ADEM, ALE, PIL, PIS, PIF: badv_code = 1'b1;
            default:                              badv_code = 1'b0;
        endcase
    end

    assign upd_badv_we = excp_take & badv_code;
    assign upd_badv    = req_badv;
    assign upd_era     = req_pc;

    // Skip the restore write when PRMD already matches CRMD
    assign mode_change = (prmd_pplv != crmd_plv) | (prmd_pie != crmd_ie);
    assign upd_ertn    = ertn_take & mode_change;

endmodule

/* verilog/int_pending.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module int_pending (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               ti_in,
    input  logic               ti_clr,
    input  logic [1:0]         swi_in,
    input  logic [1:0]         swi_clr,
    input  logic [`HWI_N-1:0]  hwi_in,

    output logic [`INT_W-1:0]  int_vec
);

    logic [`INT_W-1:0] line_vec;
    logic [`INT_W-1:0] clr_vec;
    logic [`INT_W-1:0] pend_q;

    // Bit 10 reserved and bit 12 left for IPI
    assign line_vec = {1'b0, ti_in, 1'b0, hwi_in, swi_in};
    assign clr_vec  = {1'b0, ti_clr, 1'b0, {`HWI_N{1'b0}}, swi_clr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q  <= '0;
            int_vec <= '0;
        end else begin
            // Sticky until cleared or set again by a live line
            pend_q  <= (pend_q & ~clr_vec) | line_vec;
            int_vec <= pend_q;
        end
    end

endmodule

/* verilog/commit_req_stage.sv */
`timescale 1ns/1ns
`include "excp_params.svh"

module commit_req_stage (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 flush,

    // Retiring instruction from mem stage
    input  logic                 commit_valid,
    input  logic                 commit_excp,
    input  logic                 commit_ertn,
    input  logic [`ADDR_W-1:0]   commit_pc,
    input  logic [`ADDR_W-1:0]   commit_badv,
    input  excp_pkg::ecode_t     commit_ecode,

    // Registered request
    output logic                 req_valid,
    output logic                 req_excp,
    output logic                 req_ertn,
    output logic [`ADDR_W-1:0]   req_pc,
    output logic [`ADDR_W-1:0]   req_badv,
    output excp_pkg::ecode_t     req_ecode
);

    logic take;

    // Younger instruction behind a redirect is dropped
    assign take = commit_valid & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            req_excp  <= 1'b0;
            req_ertn  <= 1'b0;
        end else begin
            req_valid <= take;
            req_excp  <= take & commit_excp;
            req_ertn  <= take & commit_ertn;
        end
    end

    // Payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (take) begin
            req_pc    <= commit_pc;
            req_badv  <= commit_badv;
            req_ecode <= commit_ecode;
        end
    end

endmodule

/* verilog/excp_pkg.sv */
package excp_pkg;

    ////////////////////////////////////////
    // Exception codes
    ////////////////////////////////////////

    // ESTAT.Ecode values with ADEM split off from ADE
    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADEF = 6'h08,
        ALE  = 6'h09,
        ADEM = 6'h0A,
        SYS  = 6'h0B,
        BRK  = 6'h0C,
        INE  = 6'h0D,
        TLBR = 6'h3F
    } ecode_t;

    ////////////////////////////////////////
    // Privilege levels
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        USER   = 2'd3
    } plv_t;

    ////////////////////////////////////////
    // CSR numbers
    ////////////////////////////////////////

    typedef enum logic [13:0] {
        CRMD      = 14'h000,
        PRMD      = 14'h001,
        ECFG      = 14'h004,
        ESTAT     = 14'h005,
        ERA       = 14'h006,
        BADV      = 14'h007,
        EENTRY    = 14'h00C,
        TLBRENTRY = 14'h088
    } csr_addr_t;

endpackage

/* verilog/excp_params.svh */
`ifndef EXCP_PARAMS_SVH
`define EXCP_PARAMS_SVH

// Virtual address width
`define ADDR_W 32

// ESTAT.IS / ECFG.LIE width
`define INT_W 13

// Hardware interrupt lines
`define HWI_N 8

`endif
